// ==== dma_target_pkg.sv ====
// Shared definitions for the DMA transfer target
// Flit layout and header field positions
// Flit and packet type codes, word and tile types
// Controller state encoding
package dma_target_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Flit layout
  //////////////////////////////////////////////////////////////////////////

  localparam int FLIT_W    = 34;
  localparam int CONTENT_W = 32;

  // Flit type sits above the payload
  localparam int FLIT_TYPE_MSB = 33;
  localparam int FLIT_TYPE_LSB = 32;
  localparam int CONTENT_MSB   = 31;
  localparam int CONTENT_LSB   = 0;

  // Header fields
  localparam int DEST_MSB  = 31;
  localparam int DEST_LSB  = 28;
  localparam int CLASS_MSB = 27;
  localparam int CLASS_LSB = 25;
  localparam int ID_MSB    = 24;
  localparam int ID_LSB    = 21;
  localparam int SRC_MSB   = 20;
  localparam int SRC_LSB   = 17;
  localparam int TYPE_MSB  = 16;
  localparam int TYPE_LSB  = 15;
  localparam int SIZE_MSB  = 14;
  localparam int SIZE_LSB  = 7;

  // Request headers carry end of request, response headers last packet
  localparam int REQ_LAST_BIT = 6;
  localparam int RES_LAST_BIT = 6;

  localparam logic [CLASS_MSB-CLASS_LSB:0] PKT_CLASS_DMA = 3'd2;

  // Byte step between two local words
  localparam int WORD_BYTES = 4;

  //////////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////////

  // Top bit set marks the last flit of a packet
  typedef enum logic [1:0] {
    flit_payload = 2'b00,
    flit_header  = 2'b01,
    flit_last    = 2'b10,
    flit_single  = 2'b11
  } flit_type_t;

  typedef enum logic [1:0] {
    pkt_l2r_req  = 2'b00,
    pkt_r2l_req  = 2'b01,
    pkt_l2r_resp = 2'b10,
    pkt_r2l_resp = 2'b11
  } pkt_type_t;

  typedef logic [SRC_MSB-SRC_LSB:0]   tile_t;
  typedef logic [SIZE_MSB-SIZE_LSB:0] size_t;

  // Controller states
  typedef enum logic [3:0] {
    st_idle      = 4'd0,
    st_l2r_addr  = 4'd1,
    st_l2r_data  = 4'd2,
    st_l2r_resp  = 4'd3,
    st_r2l_laddr = 4'd4,
    st_r2l_raddr = 4'd5,
    st_r2l_hdr   = 4'd6,
    st_r2l_addr  = 4'd7,
    st_r2l_data  = 4'd8
  } state_t;

endpackage

// ==== dma_flit_buffer.sv ====
// Circular flit buffer between NoC input and the target controller
// Stores the packet last bit beside every flit
`timescale 1ns/10ps

module dma_flit_buffer
  import dma_target_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [FLIT_W-1:0] in_flit,
  input  logic              in_last,
  input  logic              in_valid,
  output logic              in_ready,
  output logic [FLIT_W-1:0] out_flit,
  output logic              out_last,
  output logic              out_valid,
  input  logic              out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry is {last, flit}
  logic [FLIT_W:0]  entries [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Pointer advance with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign wr_en     = in_valid & in_ready;
  assign rd_en     = out_valid & out_ready;

  // Head entry seen directly, so a write shows up one cycle later
  assign out_flit = entries[rd_ptr][FLIT_W-1:0];
  assign out_last = entries[rd_ptr][FLIT_W];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[wr_ptr] <= {in_last, in_flit};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
      // Occupancy only moves on a lone push or pop
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== dma_read_fifo.sv ====
// Three-entry shifting FIFO for words read from local memory
// One-hot write position, head always in slot 0
`timescale 1ns/10ps

module dma_read_fifo
  import dma_target_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push,
  input  logic                 pop,
  input  logic [CONTENT_W-1:0] in_data,
  output logic [CONTENT_W-1:0] out_data,
  output logic                 out_valid,
  output logic                 ready
);

  logic [CONTENT_W-1:0] data [3];
  // Bit k set means next write goes to slot k, bit 3 is full
  logic [3:0]           pos;

  assign out_data  = data[0];
  assign out_valid = ~pos[0];
  // Low from two entries on, leaves a slot for the word in flight
  assign ready     = ~|pos[3:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push & ~pop) begin
      pos <= pos << 1;
    end else if (pop & ~push) begin
      pos <= pos >> 1;
    end
  end

  always_ff @(posedge clk) begin
    // Lower slots shift down on pop, or take the push into the freed slot
    for (int i = 0; i < 2; i++) begin
      if (pop) begin
        data[i] <= (push && pos[i+1]) ? in_data : data[i+1];
      end else if (push && pos[i]) begin
        data[i] <= in_data;
      end
    end
    // Top slot only ever takes new data
    if (push && (pop ? pos[3] : pos[2])) begin
      data[2] <= in_data;
    end
  end

endmodule

// ==== dma_target_ctrl.sv ====
// DMA target control FSM
// Parses request packets from the flit buffer, drives the memory bus
// and builds L2R and R2L response flits
`timescale 1ns/10ps

module dma_target_ctrl
  import dma_target_pkg::*;
#(
  parameter int    NOC_PACKET_SIZE = 16,
  parameter tile_t TILE_ID         = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [FLIT_W-1:0]    buf_flit,
  input  logic                 buf_last,
  input  logic                 buf_valid,
  output logic                 buf_ready,
  output logic                 fifo_push,
  output logic                 fifo_pop,
  input  logic [CONTENT_W-1:0] fifo_data,
  input  logic                 fifo_valid,
  input  logic                 fifo_ready,
  output logic [FLIT_W-1:0]    noc_out_flit,
  output logic                 noc_out_last,
  output logic                 noc_out_valid,
  input  logic                 noc_out_ready,
  output logic                 mem_sel,
  output logic                 mem_write,
  output logic [CONTENT_W-1:0] mem_addr,
  output logic [CONTENT_W-1:0] mem_wdata,
  input  logic                 mem_ready
);

  // Header and address flit leave room for this many data flits
  localparam size_t                MAX_WORDS = size_t'(NOC_PACKET_SIZE - 2);
  localparam logic [CONTENT_W-1:0] ADDR_STEP = CONTENT_W'(WORD_BYTES);

  state_t                 state;
  state_t                 nxt_state;
  logic [CONTENT_W-1:0]   addr;
  logic [CONTENT_W-1:0]   nxt_addr;
  logic [CONTENT_W-1:0]   raddr;
  logic [CONTENT_W-1:0]   nxt_raddr;
  tile_t                  src_tile;
  tile_t                  nxt_src_tile;
  logic [ID_MSB-ID_LSB:0] pkt_id;
  logic [ID_MSB-ID_LSB:0] nxt_pkt_id;
  size_t                  req_size;
  size_t                  nxt_req_size;
  logic                   end_req;
  logic                   nxt_end_req;
  // Words sent in finished packets, words read from the bus
  size_t                  words_sent;
  size_t                  nxt_words_sent;
  size_t                  rd_count;
  size_t                  nxt_rd_count;
  // Current packet size and index of the data flit on the output
  size_t                  pkt_words;
  size_t                  nxt_pkt_words;
  size_t                  pkt_count;
  size_t                  nxt_pkt_count;
  // Bus held off for one or more cycles after the FIFO filled up
  logic                   bus_wait;
  logic                   nxt_bus_wait;

  size_t                  remaining;
  size_t                  pkt_size;
  logic                   pkt_final;
  logic [FLIT_W-1:0]      resp_flit;

  assign remaining = req_size - words_sent;
  assign pkt_final = (remaining <= MAX_WORDS);
  assign pkt_size  = pkt_final ? remaining : MAX_WORDS;

  assign mem_addr     = addr;
  assign mem_wdata    = buf_flit[CONTENT_MSB:CONTENT_LSB];
  assign noc_out_last = noc_out_flit[FLIT_TYPE_MSB];

  // Fields shared by both response headers
  always_comb begin
    resp_flit = '0;
    resp_flit[DEST_MSB:DEST_LSB]   = src_tile;
    resp_flit[CLASS_MSB:CLASS_LSB] = PKT_CLASS_DMA;
    resp_flit[ID_MSB:ID_LSB]       = pkt_id;
    resp_flit[SRC_MSB:SRC_LSB]     = TILE_ID;
  end

  //////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state      = state;
    nxt_addr       = addr;
    nxt_raddr      = raddr;
    nxt_src_tile   = src_tile;
    nxt_pkt_id     = pkt_id;
    nxt_req_size   = req_size;
    nxt_end_req    = end_req;
    nxt_words_sent = words_sent;
    nxt_rd_count   = rd_count;
    nxt_pkt_words  = pkt_words;
    nxt_pkt_count  = pkt_count;
    nxt_bus_wait   = bus_wait;
    buf_ready      = 1'b0;
    fifo_push      = 1'b0;
    fifo_pop       = 1'b0;
    mem_sel        = 1'b0;
    mem_write      = 1'b0;
    noc_out_valid  = 1'b0;
    noc_out_flit   = '0;

    case (state)
      st_idle: begin
        // Header is consumed here, unknown types are dropped
        buf_ready    = 1'b1;
        nxt_bus_wait = 1'b0;
        if (buf_valid) begin
          nxt_src_tile   = buf_flit[SRC_MSB:SRC_LSB];
          nxt_pkt_id     = buf_flit[ID_MSB:ID_LSB];
          nxt_req_size   = buf_flit[SIZE_MSB:SIZE_LSB];
          nxt_end_req    = buf_flit[REQ_LAST_BIT];
          nxt_words_sent = '0;
          nxt_rd_count   = '0;
          if (buf_flit[TYPE_MSB:TYPE_LSB] == pkt_l2r_req) begin
            nxt_state = st_l2r_addr;
          end else if (buf_flit[TYPE_MSB:TYPE_LSB] == pkt_r2l_req) begin
            nxt_state = st_r2l_laddr;
          end
        end
      end

      st_l2r_addr: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          nxt_addr  = buf_flit[CONTENT_MSB:CONTENT_LSB];
          nxt_state = st_l2r_data;
        end
      end

      st_l2r_data: begin
        // One write per payload flit, flit held until the bus accepts
        mem_sel   = buf_valid;
        mem_write = buf_valid;
        buf_ready = mem_ready;
        if (buf_valid && mem_ready) begin
          nxt_addr = addr + ADDR_STEP;
          if (buf_last) begin
            nxt_state = end_req ? st_l2r_resp : st_idle;
          end
        end
      end

      st_l2r_resp: begin
        noc_out_valid = 1'b1;
        noc_out_flit  = resp_flit;
        noc_out_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB] = flit_single;
        noc_out_flit[TYPE_MSB:TYPE_LSB]           = pkt_l2r_resp;
        if (noc_out_ready) nxt_state = st_idle;
      end

      st_r2l_laddr: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          nxt_addr  = buf_flit[CONTENT_MSB:CONTENT_LSB];
          nxt_state = st_r2l_raddr;
        end
      end

      st_r2l_raddr: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          nxt_raddr = buf_flit[CONTENT_MSB:CONTENT_LSB];
          nxt_state = st_r2l_hdr;
        end
      end

      st_r2l_hdr: begin
        noc_out_valid = 1'b1;
        noc_out_flit  = resp_flit;
        noc_out_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB] = flit_header;
        noc_out_flit[TYPE_MSB:TYPE_LSB]           = pkt_r2l_resp;
        noc_out_flit[SIZE_MSB:SIZE_LSB]           = pkt_size;
        noc_out_flit[RES_LAST_BIT]                = pkt_final;
        nxt_pkt_words = pkt_size;
        nxt_pkt_count = size_t'(1);
        if (noc_out_ready) nxt_state = st_r2l_addr;
      end

      st_r2l_addr: begin
        // Remote address of the first word in this packet
        noc_out_valid = 1'b1;
        noc_out_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB] = flit_payload;
        noc_out_flit[CONTENT_MSB:CONTENT_LSB] =
          raddr + CONTENT_W'(words_sent) * ADDR_STEP;
        if (noc_out_ready) nxt_state = st_r2l_data;
      end

      st_r2l_data: begin
        // NoC side drains the FIFO
        noc_out_valid = fifo_valid;
        noc_out_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB] =
          (pkt_count == pkt_words) ? flit_last : flit_payload;
        noc_out_flit[CONTENT_MSB:CONTENT_LSB] = fifo_data;
        if (fifo_valid && noc_out_ready) begin
          fifo_pop = 1'b1;
          if (pkt_count == pkt_words) begin
            nxt_words_sent = words_sent + pkt_words;
            nxt_state      = pkt_final ? st_idle : st_r2l_hdr;
          end else begin
            nxt_pkt_count = pkt_count + 1'b1;
          end
        end
        // Bus side fills the FIFO until the whole request is read
        if (bus_wait) begin
          nxt_bus_wait = ~fifo_ready;
        end else if (rd_count != req_size) begin
          mem_sel = 1'b1;
          if (mem_ready) begin
            fifo_push    = 1'b1;
            nxt_addr     = addr + ADDR_STEP;
            nxt_rd_count = rd_count + 1'b1;
            // Word landed in the spare slot, pause one bus cycle
            nxt_bus_wait = ~fifo_ready;
          end
        end
      end

      default: nxt_state = st_idle;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      words_sent <= '0;
      rd_count   <= '0;
      pkt_words  <= '0;
      pkt_count  <= '0;
      bus_wait   <= 1'b0;
      end_req    <= 1'b0;
    end else begin
      state      <= nxt_state;
      words_sent <= nxt_words_sent;
      rd_count   <= nxt_rd_count;
      pkt_words  <= nxt_pkt_words;
      pkt_count  <= nxt_pkt_count;
      bus_wait   <= nxt_bus_wait;
      end_req    <= nxt_end_req;
    end
  end

  // Request fields and addresses
  always_ff @(posedge clk) begin
    addr     <= nxt_addr;
    raddr    <= nxt_raddr;
    src_tile <= nxt_src_tile;
    pkt_id   <= nxt_pkt_id;
    req_size <= nxt_req_size;
  end

endmodule

// ==== dma_transfer_target.sv ====
// DMA transfer target top level
// Input flit buffer, read-data FIFO and control FSM
`timescale 1ns/10ps

module dma_transfer_target
  import dma_target_pkg::*;
#(
  parameter int    NOC_PACKET_SIZE = 16,
  parameter tile_t TILE_ID         = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  // NoC input
  input  logic [FLIT_W-1:0]    noc_in_flit,
  input  logic                 noc_in_last,
  input  logic                 noc_in_valid,
  output logic                 noc_in_ready,
  // NoC output
  output logic [FLIT_W-1:0]    noc_out_flit,
  output logic                 noc_out_last,
  output logic                 noc_out_valid,
  input  logic                 noc_out_ready,
  // Local memory bus
  output logic                 mem_sel,
  output logic                 mem_write,
  output logic [CONTENT_W-1:0] mem_addr,
  output logic [CONTENT_W-1:0] mem_wdata,
  input  logic [CONTENT_W-1:0] mem_rdata,
  input  logic                 mem_ready
);

  logic [FLIT_W-1:0]    buf_flit;
  logic                 buf_last;
  logic                 buf_valid;
  logic                 buf_ready;
  logic                 fifo_push;
  logic                 fifo_pop;
  logic [CONTENT_W-1:0] fifo_data;
  logic                 fifo_valid;
  logic                 fifo_ready;

  // One packet deep
  dma_flit_buffer #(
    .DEPTH (NOC_PACKET_SIZE)
  ) i_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_last   (noc_in_last),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_last  (buf_last),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  // Read words straight from the bus
  dma_read_fifo i_read_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (fifo_push),
    .pop       (fifo_pop),
    .in_data   (mem_rdata),
    .out_data  (fifo_data),
    .out_valid (fifo_valid),
    .ready     (fifo_ready)
  );

  dma_target_ctrl #(
    .NOC_PACKET_SIZE (NOC_PACKET_SIZE),
    .TILE_ID         (TILE_ID)
  ) i_ctrl (
    .clk           (clk),
    .rst           (rst),
    .buf_flit      (buf_flit),
    .buf_last      (buf_last),
    .buf_valid     (buf_valid),
    .buf_ready     (buf_ready),
    .fifo_push     (fifo_push),
    .fifo_pop      (fifo_pop),
    .fifo_data     (fifo_data),
    .fifo_valid    (fifo_valid),
    .fifo_ready    (fifo_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_last  (noc_out_last),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .mem_sel       (mem_sel),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_ready     (mem_ready)
  );

endmodule

// ==== tb_dma_transfer_target.sv ====
// Testbench for the DMA transfer target
// Memory model with random ready, random NoC output back-pressure
// Request table applied in a loop, response checker and watchdog
`timescale 1ns/10ps

module tb_dma_transfer_target
  import dma_target_pkg::*;
;

  localparam int    NOC_PACKET_SIZE = 16;
  localparam int    MAX_WORDS       = NOC_PACKET_SIZE - 2;
  localparam tile_t TILE_ID         = 4'd6;
  localparam int    SEED            = 32'h48ec9397;
  localparam int    NUM_ROWS        = 7;
  localparam int    ROW_CYCLES      = 200;

  // One request per row
  typedef struct packed {
    pkt_type_t   ptype;
    logic [3:0]  id;
    tile_t       src;
    size_t       size;
    logic        end_bit;
    logic [31:0] laddr;
    logic [31:0] raddr;
    logic [31:0] base;
  } req_t;

  // Local regions of the rows do not overlap
  localparam req_t ROWS [NUM_ROWS] = '{
    '{pkt_l2r_req, 4'd3,  4'd5,  8'd4,  1'b1, 32'h0000_0040, 32'h0000_0000, 32'h1000_0000},
    '{pkt_l2r_req, 4'd7,  4'd2,  8'd6,  1'b0, 32'h0000_0100, 32'h0000_0000, 32'h2222_0000},
    '{pkt_r2l_req, 4'd1,  4'd9,  8'd5,  1'b1, 32'h0000_0200, 32'h8000_0000, 32'h0000_0000},
    '{pkt_r2l_req, 4'd12, 4'd3,  8'd14, 1'b1, 32'h0000_0280, 32'h0001_2340, 32'h0000_0000},
    '{pkt_r2l_req, 4'd6,  4'd14, 8'd20, 1'b1, 32'h0000_0300, 32'h4000_1000, 32'h0000_0000},
    '{pkt_l2r_req, 4'd15, 4'd1,  8'd20, 1'b1, 32'h0000_03a0, 32'h0000_0000, 32'habcd_0100},
    '{pkt_r2l_req, 4'd2,  4'd0,  8'd1,  1'b0, 32'h0000_0010, 32'h0000_0ffc, 32'h0000_0000}
  };

  logic                 clk = 1'b0;
  logic                 rst;
  logic [FLIT_W-1:0]    noc_in_flit;
  logic                 noc_in_last;
  logic                 noc_in_valid;
  logic                 noc_in_ready;
  logic [FLIT_W-1:0]    noc_out_flit;
  logic                 noc_out_last;
  logic                 noc_out_valid;
  logic                 noc_out_ready = 1'b0;
  logic                 mem_sel;
  logic                 mem_write;
  logic [CONTENT_W-1:0] mem_addr;
  logic [CONTENT_W-1:0] mem_wdata;
  logic [CONTENT_W-1:0] mem_rdata;
  logic                 mem_ready = 1'b0;

  integer               seed     = SEED;
  integer               out_seed = SEED ^ 32'h5a5a_5a5a;
  logic [31:0]          mem [256];
  // Flits seen on the output and flits expected as {last, flit}
  logic [FLIT_W:0]      out_q [$];
  logic [FLIT_W:0]      exp_q [$];
  int                   writes_seen = 0;

  dma_transfer_target #(
    .NOC_PACKET_SIZE (NOC_PACKET_SIZE),
    .TILE_ID         (TILE_ID)
  ) i_dut (
    .clk           (clk),
    .rst           (rst),
    .noc_in_flit   (noc_in_flit),
    .noc_in_last   (noc_in_last),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_last  (noc_out_last),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .mem_sel       (mem_sel),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata),
    .mem_ready     (mem_ready)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Memory fill pattern that depends on every address bit
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'h5c, 8'ha7, ~idx, idx};
  endfunction

  function automatic logic [FLIT_W-1:0] make_header(
    input flit_type_t ft, input pkt_type_t pt, input tile_t dest, input tile_t src,
    input logic [3:0] id, input size_t size, input logic last_bit);
    logic [FLIT_W-1:0] f;
    f = '0;
    f[FLIT_TYPE_MSB:FLIT_TYPE_LSB] = ft;
    f[DEST_MSB:DEST_LSB]           = dest;
    f[CLASS_MSB:CLASS_LSB]         = PKT_CLASS_DMA;
    f[ID_MSB:ID_LSB]               = id;
    f[SRC_MSB:SRC_LSB]             = src;
    f[TYPE_MSB:TYPE_LSB]           = pt;
    f[SIZE_MSB:SIZE_LSB]           = size;
    if (pt == pkt_l2r_req || pt == pkt_r2l_req) f[REQ_LAST_BIT] = last_bit;
    else f[RES_LAST_BIT] = last_bit;
    return f;
  endfunction

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is %h, expected %h", name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Starts on a falling edge and returns on the falling edge after the handshake
  task automatic send_flit(input logic [FLIT_W-1:0] flit, input logic last_bit);
    logic taken;
    noc_in_flit  = flit;
    noc_in_last  = last_bit;
    noc_in_valid = 1'b1;
    taken        = 1'b0;
    while (!taken) begin
      taken = noc_in_ready;
      @(negedge clk);
    end
  endtask

  task automatic send_request(input req_t row);
    logic       last_bit;
    flit_type_t ft;
    send_flit(make_header(flit_header, row.ptype, TILE_ID, row.src, row.id,
                          row.size, row.end_bit), 1'b0);
    send_flit({flit_payload, row.laddr}, 1'b0);
    if (row.ptype == pkt_l2r_req) begin
      for (int k = 0; k < int'(row.size); k++) begin
        last_bit = (k == int'(row.size) - 1);
        ft       = last_bit ? flit_last : flit_payload;
        send_flit({ft, row.base + 32'(k)}, last_bit);
      end
    end else begin
      send_flit({flit_last, row.raddr}, 1'b1);
    end
    noc_in_valid = 1'b0;
  endtask

  // Packets of at most MAX_WORDS data flits with the last one flagged in its header
  task automatic expect_r2l(input req_t row);
    int         sent;
    int         n;
    logic       fin;
    logic       last_bit;
    flit_type_t ft;
    sent = 0;
    while (sent < int'(row.size)) begin
      n   = int'(row.size) - sent;
      fin = (n <= MAX_WORDS);
      if (!fin) n = MAX_WORDS;
      exp_q.push_back({1'b0, make_header(flit_header, pkt_r2l_resp, row.src, TILE_ID,
                                         row.id, size_t'(n), fin)});
      exp_q.push_back({1'b0, flit_payload, row.raddr + 32'(sent * WORD_BYTES)});
      for (int k = 0; k < n; k++) begin
        last_bit = (k == n - 1);
        ft       = last_bit ? flit_last : flit_payload;
        exp_q.push_back({last_bit, ft, fill_word(row.laddr[9:2] + 8'(sent + k))});
      end
      sent = sent + n;
    end
  endtask

  task automatic check_l2r_memory(input req_t row);
    logic [7:0] idx;
    for (int k = 0; k < int'(row.size); k++) begin
      idx = row.laddr[9:2] + 8'(k);
      check($sformatf("mem[%0d]", idx), 64'(mem[idx]), 64'(row.base + 32'(k)));
    end
  endtask

  task automatic compare_responses();
    check("response flit count", 64'(out_q.size()), 64'(exp_q.size()));
    for (int i = 0; i < exp_q.size(); i++) begin
      check("{noc_out_last, noc_out_flit}", 64'(out_q[i]), 64'(exp_q[i]));
    end
    out_q.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and output monitor
  ////////////////////////////////////////////////////////////////////////////

  // Memory ready about three cycles in four and NoC output ready about half
  always @(negedge clk) begin
    mem_ready     = ($random(seed) & 3) != 0;
    noc_out_ready = ($random(out_seed) & 1) != 0;
  end

  // Read data belongs to the transfer cycle
  assign mem_rdata = mem[mem_addr[9:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) mem[i] <= fill_word(8'(i));
    end else if (mem_sel && mem_write && mem_ready) begin
      mem[mem_addr[9:2]] <= mem_wdata;
      writes_seen++;
    end
  end

  always @(posedge clk) begin
    if (!rst && noc_out_valid && noc_out_ready) begin
      out_q.push_back({noc_out_last, noc_out_flit});
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    req_t row;
    int   wr_start;
    rst          = 1'b1;
    noc_in_flit  = '0;
    noc_in_last  = 1'b0;
    noc_in_valid = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      row = ROWS[r];
      exp_q.delete();
      wr_start = writes_seen;
      send_request(row);
      if (row.ptype == pkt_l2r_req) begin
        while (writes_seen != wr_start + int'(row.size)) @(negedge clk);
        check_l2r_memory(row);
        if (row.end_bit) begin
          exp_q.push_back({1'b1, make_header(flit_single, pkt_l2r_resp, row.src, TILE_ID,
                                             row.id, 8'd0, 1'b0)});
        end
      end else begin
        expect_r2l(row);
      end
      while (out_q.size() < exp_q.size()) @(negedge clk);
      // Quiet window to catch flits beyond the expected ones
      repeat (4) @(negedge clk);
      compare_responses();
      // Reads never write and writes stop at the request size
      check("mem_write transfer count", 64'(writes_seen - wr_start),
            64'((row.ptype == pkt_l2r_req) ? int'(row.size) : 0));
    end
    $display("*** PASSED ***");
    $finish;
  end

  initial begin : watchdog
    repeat (16 + NUM_ROWS * ROW_CYCLES) @(posedge clk);
    $display("Timeout: the requests did not complete within %0d cycles",
             16 + NUM_ROWS * ROW_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== vlog.f ====
dma_target_pkg.sv
dma_flit_buffer.sv
dma_read_fifo.sv
dma_target_ctrl.sv
dma_transfer_target.sv
tb_dma_transfer_target.sv

// ==== Makefile ====
# Verilator build and run for the DMA transfer target

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_dma_transfer_target
LINT_TOP  ?= dma_transfer_target
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
